//--- common/hps_pkg.sv
// host link types: bus word, command opcodes, config and download structs, ps2 tx states
`default_nettype none

package hps_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int HOST_W    = 16;
	localparam int DL_ADDR_W = 25;

	// one sample of the host bus
	typedef struct packed {
		logic              active;
		logic              strobe;
		logic [HOST_W-1:0] data;
	} hps_word_t;

	typedef enum logic [HOST_W-1:0] {
		CMD_CFG         = 16'h0001,
		CMD_JOY0        = 16'h0002,
		CMD_JOY1        = 16'h0003,
		CMD_KBD         = 16'h0005,
		CMD_CONF_STR    = 16'h0014,
		CMD_STATUS      = 16'h001E,
		CMD_STATUS_REQ  = 16'h0029,
		CMD_FILE_TX     = 16'h0053,
		CMD_FILE_TX_DAT = 16'h0054,
		CMD_FILE_INDEX  = 16'h0055
	} host_cmd_e;

	////////////////////////////////////////
	// core side outputs
	////////////////////////////////////////

	typedef struct packed {
		logic [1:0]  buttons;
		logic        forced_scandoubler;
		logic [15:0] joystick_0;
		logic [15:0] joystick_1;
		logic [31:0] status;
	} user_cfg_t;

	// byte wide download port
	typedef struct packed {
		logic                 download;
		logic                 wr;
		logic [7:0]           index;
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           dout;
	} ioctl_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_HOLD,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} ps2_tx_state_e;

endpackage

`default_nettype wire

//--- flist.f
+incdir+verification
common/hps_pkg.sv
host_link/cmd_link.sv
host_link/file_loader.sv
ps2/ps2_tx_fifo.sv
ps2/ps2_kbd_tx.sv
source/hps_io.sv
verification/tb_hps_io.sv

//--- host_link/cmd_link.sv
// host command decoder: word counter, config registers, status request and readback
`default_nettype none
`timescale 1ns/1ns

module cmd_link
	import hps_pkg::*;
#(
	parameter int STRLEN = 4
) (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire hps_word_t     host_in,
	input  wire [8*STRLEN-1:0] conf_str,
	input  wire [31:0]         status_in,
	input  wire                status_set,
	output logic [HOST_W-1:0]  host_dout,
	output user_cfg_t          cfg,
	output logic [7:0]         kbd_data,
	output logic               kbd_we
);

	// wide enough to saturate past the end of the config string
	localparam int CNT_W = $clog2(STRLEN + 4);

	logic [CNT_W-1:0] word_cnt;
	host_cmd_e        cmd;
	logic             payload_stb;
	logic             old_status_set;
	logic             status_rise;
	logic [3:0]       req_cnt;
	logic [31:0]      status_req;
	logic [7:0]       conf_byte;

	assign payload_stb = host_in.active && host_in.strobe && (word_cnt != '0);
	assign status_rise = status_set && !old_status_set;

	// byte k of conf_str, first byte at the top
	always_comb begin
		conf_byte = '0;
		for (int k = 1; k <= STRLEN; k++) begin
			if (int'(word_cnt) == k) begin
				conf_byte = conf_str[(STRLEN - k)*8 +: 8];
			end
		end
	end

	////////////////////////////////////////
	// status change request
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			old_status_set <= 1'b0;
			req_cnt        <= '0;
		end else begin
			old_status_set <= status_set;
			if (status_rise) begin
				req_cnt <= req_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_rise) begin
			status_req <= status_in;
		end
		if (payload_stb && cmd == CMD_KBD) begin
			kbd_data <= host_in.data[7:0];
		end
	end

	////////////////////////////////////////
	// command decode and readback
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt  <= '0;
			cmd       <= host_cmd_e'(16'h0000);
			host_dout <= '0;
			cfg       <= '0;
			kbd_we    <= 1'b0;
		end else begin
			kbd_we <= 1'b0;
			if (!host_in.active) begin
				word_cnt  <= '0;
				host_dout <= '0;
			end else if (host_in.strobe) begin
				host_dout <= '0;
				if (word_cnt != '1) begin
					word_cnt <= word_cnt + CNT_W'(1);
				end
				if (word_cnt == '0) begin
					cmd <= host_cmd_e'(host_in.data);
					// request counter goes back on the command word itself
					if (host_in.data == CMD_STATUS_REQ) begin
						host_dout <= {8'h00, 4'hA, req_cnt};
					end
				end else begin
					case (cmd)
						CMD_CFG: begin
							cfg.buttons            <= host_in.data[1:0];
							cfg.forced_scandoubler <= host_in.data[4];
						end
						CMD_JOY0:     cfg.joystick_0 <= host_in.data;
						CMD_JOY1:     cfg.joystick_1 <= host_in.data;
						CMD_KBD:      kbd_we <= 1'b1;
						CMD_CONF_STR: host_dout <= {8'h00, conf_byte};
						CMD_STATUS: begin
							if (word_cnt == CNT_W'(1)) begin
								cfg.status[15:0] <= host_in.data;
							end else if (word_cnt == CNT_W'(2)) begin
								cfg.status[31:16] <= host_in.data;
							end
						end
						CMD_STATUS_REQ: begin
							if (word_cnt == CNT_W'(1)) begin
								host_dout <= status_req[15:0];
							end else if (word_cnt == CNT_W'(2)) begin
								host_dout <= status_req[31:16];
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	// host only strobes inside a frame
	a_strobe_in_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		host_in.strobe |-> host_in.active);

endmodule

`default_nettype wire

//--- host_link/file_loader.sv
// file download decoder: index, start and end of transfer, address counter and write pulse
`default_nettype none
`timescale 1ns/1ns

module file_loader
	import hps_pkg::*;
(
	input  wire            clk_sys,
	input  wire            rst_n,
	input  wire hps_word_t host_in,
	output ioctl_t         ioctl
);

	host_cmd_e            cmd;
	logic                 has_cmd;
	logic                 data_stb;
	logic                 dl_active;
	logic                 wr_d;
	logic                 wr_q;
	logic [7:0]           index_q;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [DL_ADDR_W-1:0] addr_q;
	logic [7:0]           dout_q;

	assign data_stb = host_in.active && host_in.strobe && has_cmd;

	assign ioctl = '{download: dl_active, wr: wr_q, index: index_q,
		addr: addr_q, dout: dout_q};

	// wr goes out one cycle after addr and dout settle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd       <= host_cmd_e'(16'h0000);
			has_cmd   <= 1'b0;
			dl_active <= 1'b0;
			wr_d      <= 1'b0;
			wr_q      <= 1'b0;
		end else begin
			wr_q <= wr_d;
			wr_d <= 1'b0;
			if (!host_in.active) begin
				has_cmd <= 1'b0;
			end else if (host_in.strobe && !has_cmd) begin
				cmd     <= host_cmd_e'(host_in.data);
				has_cmd <= 1'b1;
			end
			if (data_stb) begin
				case (cmd)
					CMD_FILE_TX:     dl_active <= (host_in.data[7:0] != 8'h00);
					CMD_FILE_TX_DAT: wr_d <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_stb) begin
			case (cmd)
				CMD_FILE_INDEX: index_q <= host_in.data[7:0];
				CMD_FILE_TX: begin
					// nonzero starts a transfer, zero ends it with the final count
					if (host_in.data[7:0] != 8'h00) begin
						dl_addr <= '0;
					end else begin
						addr_q <= dl_addr;
					end
				end
				CMD_FILE_TX_DAT: begin
					addr_q  <= dl_addr;
					dout_q  <= host_in.data[7:0];
					dl_addr <= dl_addr + DL_ADDR_W'(1);
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- ps2/ps2_kbd_tx.sv
// ps2 keyboard device transmitter with clock divider, hold-off and 11-bit frame shifter
`default_nettype none
`timescale 1ns/1ns

module ps2_kbd_tx
	import hps_pkg::*;
#(
	parameter int PS2_DIV   = 2000,
	parameter int FIFO_BITS = 5
) (
	input  wire       clk_sys,
	input  wire       rst_n,
	input  wire [7:0] wdata,
	input  wire       we,
	output logic      ps2_kbd_clk_out,
	output logic      ps2_kbd_data_out
);

	localparam int DIV_W = $clog2(PS2_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic             ps2_clk;
	logic             div_end;
	logic             ps2_rise;
	logic             ps2_fall;
	logic [7:0]       fifo_data;
	logic             fifo_ne;
	logic             pop;
	ps2_tx_state_e    state;
	logic [1:0]       hold_cnt;
	logic [3:0]       bit_cnt;
	logic [7:0]       tx_byte;
	logic             parity;

	ps2_tx_fifo #(
		.FIFO_BITS(FIFO_BITS)
	) u_fifo (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.wdata    (wdata),
		.we       (we),
		.pop      (pop),
		.rdata    (fifo_data),
		.not_empty(fifo_ne)
	);

	assign div_end  = (div_cnt == DIV_W'(PS2_DIV - 1));
	assign ps2_rise = div_end && !ps2_clk;
	assign ps2_fall = div_end && ps2_clk;
	assign pop      = (state == TX_HOLD) && ps2_rise && (hold_cnt == 2'd3);

	////////////////////////////////////////
	// ps2 clock with a period of 2*PS2_DIV
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ps2_clk <= 1'b0;
		end else if (div_end) begin
			div_cnt <= '0;
			ps2_clk <= !ps2_clk;
		end else begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	// shift register and odd parity
	always_ff @(posedge clk_sys) begin
		if (pop) begin
			tx_byte <= fifo_data;
			parity  <= ~^fifo_data;
		end else if (state == TX_DATA && ps2_rise && bit_cnt != 4'd8) begin
			tx_byte <= {1'b0, tx_byte[7:1]};
		end
	end

	////////////////////////////////////////
	// frame FSM that moves data on the rise
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state            <= TX_IDLE;
			hold_cnt         <= '0;
			bit_cnt          <= '0;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else begin
			if (ps2_rise) begin
				ps2_kbd_clk_out <= 1'b1;
			end
			// clock only pulses low while a frame is on the line
			if (ps2_fall) begin
				ps2_kbd_clk_out <= (state == TX_IDLE) || (state == TX_HOLD);
			end
			case (state)
				TX_IDLE: begin
					if (fifo_ne) begin
						hold_cnt <= '0;
						state    <= TX_HOLD;
					end
				end
				TX_HOLD: begin
					if (ps2_rise) begin
						hold_cnt <= hold_cnt + 2'd1;
						if (hold_cnt == 2'd3) begin
							// start bit
							ps2_kbd_data_out <= 1'b0;
							bit_cnt          <= '0;
							state            <= TX_DATA;
						end
					end
				end
				TX_DATA: begin
					if (ps2_rise) begin
						if (bit_cnt == 4'd8) begin
							ps2_kbd_data_out <= parity;
							state            <= TX_PARITY;
						end else begin
							ps2_kbd_data_out <= tx_byte[0];
							bit_cnt          <= bit_cnt + 4'd1;
						end
					end
				end
				TX_PARITY: begin
					if (ps2_rise) begin
						ps2_kbd_data_out <= 1'b1;
						state            <= TX_STOP;
					end
				end
				TX_STOP: begin
					if (ps2_rise) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// the byte of the coming frame waits in the FIFO for the whole hold-off
	a_start_needs_data: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(state == TX_HOLD) |-> fifo_ne);

endmodule

`default_nettype wire

//--- ps2/ps2_tx_fifo.sv
// circular byte buffer between the host link and the ps2 transmitter
`default_nettype none
`timescale 1ns/1ns

module ps2_tx_fifo #(
	parameter int FIFO_BITS = 5
) (
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire [7:0]  wdata,
	input  wire        we,
	input  wire        pop,
	output logic [7:0] rdata,
	output logic       not_empty
);

	localparam int DEPTH = 1 << FIFO_BITS;

	logic [7:0]         mem [DEPTH];
	// extra top bit tells full from empty
	logic [FIFO_BITS:0] wptr;
	logic [FIFO_BITS:0] rptr;
	logic               full;

	assign not_empty = (wptr != rptr);
	assign full = (wptr[FIFO_BITS] != rptr[FIFO_BITS])
		&& (wptr[FIFO_BITS-1:0] == rptr[FIFO_BITS-1:0]);
	assign rdata = mem[rptr[FIFO_BITS-1:0]];

	always_ff @(posedge clk_sys) begin
		if (we && !full) begin
			mem[wptr[FIFO_BITS-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (we && !full) begin
				wptr <= wptr + 1'b1;
			end
			if (pop && not_empty) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	// keyboard bytes are dropped if the host outruns the ps2 line
	a_no_overflow: assert property (@(posedge clk_sys) disable iff (!rst_n)
		we |-> !full);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the hps_io testbench with verilator, run it and search the output for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_hps_io -f flist.f || exit 1
out="$(./obj_dir/Vtb_hps_io 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All tests passed" && exit 0 || exit 1

//--- source/hps_io.sv
// top level of the host link: command decoder, download port and ps2 keyboard transmitter
`default_nettype none
`timescale 1ns/1ns

module hps_io
	import hps_pkg::*;
#(
	parameter int STRLEN    = 4,
	parameter int PS2_DIV   = 2000,
	parameter int FIFO_BITS = 5
) (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire hps_word_t     host_in,
	input  wire [8*STRLEN-1:0] conf_str,
	input  wire [31:0]         status_in,
	input  wire                status_set,
	input  wire                ioctl_wait,
	output logic [HOST_W-1:0]  host_dout,
	output logic               host_wait,
	output user_cfg_t          cfg,
	output ioctl_t             ioctl,
	output logic               ps2_kbd_clk_out,
	output logic               ps2_kbd_data_out
);

	logic [7:0] kbd_data;
	logic       kbd_we;

	// no buffering, the host holds off on its own
	assign host_wait = ioctl_wait;

	cmd_link #(
		.STRLEN(STRLEN)
	) u_cmd_link (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.host_in   (host_in),
		.conf_str  (conf_str),
		.status_in (status_in),
		.status_set(status_set),
		.host_dout (host_dout),
		.cfg       (cfg),
		.kbd_data  (kbd_data),
		.kbd_we    (kbd_we)
	);

	file_loader u_file_loader (
		.clk_sys(clk_sys),
		.rst_n  (rst_n),
		.host_in(host_in),
		.ioctl  (ioctl)
	);

	ps2_kbd_tx #(
		.PS2_DIV  (PS2_DIV),
		.FIFO_BITS(FIFO_BITS)
	) u_ps2_kbd_tx (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.wdata           (kbd_data),
		.we              (kbd_we),
		.ps2_kbd_clk_out (ps2_kbd_clk_out),
		.ps2_kbd_data_out(ps2_kbd_data_out)
	);

endmodule

`default_nettype wire

//--- verification/tb_host_tasks.svh
// host bus tasks: frame enable, word strobe with wait, readback check and write pulse wait
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// raise the frame enable, the next strobe carries the command
task automatic frame_begin();
	host_in.active = 1'b1;
endtask

// drop the frame enable and leave one idle cycle
task automatic frame_end();
	host_in.active = 1'b0;
	@(posedge clk_sys);
	#2;
endtask

// one strobed word, held off while the core asks the host to wait
task automatic send_word(input logic [15:0] word);
	while (host_wait) begin
		@(posedge clk_sys);
		#2;
	end
	host_in.strobe = 1'b1;
	host_in.data   = word;
	@(posedge clk_sys);
	#2;
	host_in.strobe = 1'b0;
endtask

// answer is registered on the strobe edge
task automatic read_word(input logic [15:0] word, input logic [15:0] exp);
	send_word(word);
	expect_eq("host_dout", 32'(host_dout), 32'(exp));
endtask

// download handshake, next data word only after the write pulse
task automatic wait_write_pulse();
	while (!ioctl.wr) begin
		@(posedge clk_sys);
		#2;
	end
endtask

`endif

//--- verification/tb_hps_io.sv
// testbench for hps_io with clock, reset, checkers, timeout and the test sequence
`default_nettype none
`timescale 1ns/1ns

module tb_hps_io
	import hps_pkg::*;
();

	localparam int STRLEN    = 4;
	localparam int PS2_DIV   = 4;
	localparam int FIFO_BITS = 3;
	localparam int DL_WORDS  = 6;
	localparam int KBD_BYTES = 3;
	// the ps2 phase is the longest with about 16 ps2 periods of 2*PS2_DIV clocks per byte
	localparam int TIMEOUT_CYCLES = 20000;

	logic                clk_sys;
	logic                rst_n;
	hps_word_t           host_in;
	logic [8*STRLEN-1:0] conf_str;
	logic [31:0]         status_in;
	logic                status_set;
	logic                ioctl_wait;
	logic [HOST_W-1:0]   host_dout;
	logic                host_wait;
	user_cfg_t           cfg;
	ioctl_t              ioctl;
	logic                ps2_kbd_clk_out;
	logic                ps2_kbd_data_out;

	logic [7:0]  conf_bytes [STRLEN];
	integer      seed = 32'ha2a1_2987;
	int unsigned cycles = 0;
	user_cfg_t   exp_cfg;
	logic [31:0] rnd;
	logic [31:0] last_status;
	logic [7:0]  dl_q [$];
	logic [7:0]  kbd_q [$];
	int          wr_seen = 0;
	int          frames_seen = 0;
	int          bit_idx = 0;
	logic [10:0] frame_bits;

	`include "tb_host_tasks.svh"

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	hps_io #(
		.STRLEN   (STRLEN),
		.PS2_DIV  (PS2_DIV),
		.FIFO_BITS(FIFO_BITS)
	) UUT (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.host_in         (host_in),
		.conf_str        (conf_str),
		.status_in       (status_in),
		.status_set      (status_set),
		.ioctl_wait      (ioctl_wait),
		.host_dout       (host_dout),
		.host_wait       (host_wait),
		.cfg             (cfg),
		.ioctl           (ioctl),
		.ps2_kbd_clk_out (ps2_kbd_clk_out),
		.ps2_kbd_data_out(ps2_kbd_data_out)
	);

	////////////////////////////////////////
	// checkers
	////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_cfg();
		expect_eq("cfg.buttons", 32'(cfg.buttons), 32'(exp_cfg.buttons));
		expect_eq("cfg.forced_scandoubler", 32'(cfg.forced_scandoubler),
			32'(exp_cfg.forced_scandoubler));
		expect_eq("cfg.joystick_0", 32'(cfg.joystick_0), 32'(exp_cfg.joystick_0));
		expect_eq("cfg.joystick_1", 32'(cfg.joystick_1), 32'(exp_cfg.joystick_1));
		expect_eq("cfg.status", cfg.status, exp_cfg.status);
	endtask

	// bits[0] is the start bit and data follows LSB first
	task automatic check_frame(input logic [10:0] bits);
		logic [7:0] exp_byte;
		int         ones;
		ones = 0;
		if (kbd_q.size() == 0) begin
			abort_run("ps2 frame sent with no keyboard byte pending");
		end else begin
			exp_byte = kbd_q.pop_front();
			for (int i = 0; i < 8; i++) begin
				ones += exp_byte[i];
			end
			expect_eq("ps2 start bit", 32'(bits[0]), 32'h0);
			expect_eq("ps2 data", 32'(bits[8:1]), 32'(exp_byte));
			// data plus parity carries an odd number of ones
			expect_eq("ps2 parity", 32'(bits[9]), (ones % 2 == 0) ? 32'h1 : 32'h0);
			expect_eq("ps2 stop bit", 32'(bits[10]), 32'h1);
			frames_seen++;
		end
	endtask

	a_wait_follows: assert property (@(posedge clk_sys) host_wait == ioctl_wait)
		else abort_run($sformatf("MISMATCH host_wait: got %h, expected %h",
			host_wait, ioctl_wait));

	a_wr_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl.wr |=> !ioctl.wr)
		else abort_run("ioctl.wr stayed high for more than one cycle");

	// write pulse sampled mid cycle
	always @(negedge clk_sys) begin
		if (rst_n && ioctl.wr) begin
			if (dl_q.size() == 0) begin
				abort_run("ioctl.wr pulsed with no data word sent");
			end else begin
				expect_eq("ioctl.addr", 32'(ioctl.addr), 32'(wr_seen));
				expect_eq("ioctl.dout", 32'(ioctl.dout), 32'(dl_q.pop_front()));
				wr_seen++;
			end
		end
	end

	always @(negedge ps2_kbd_clk_out) begin
		if (rst_n) begin
			frame_bits[bit_idx] = ps2_kbd_data_out;
			if (bit_idx == 10) begin
				check_frame(frame_bits);
				bit_idx = 0;
			end else begin
				bit_idx++;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout, run did not finish within %0d cycles", cycles));
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		rst_n       = 1'b0;
		host_in     = '0;
		status_in   = '0;
		status_set  = 1'b0;
		ioctl_wait  = 1'b0;
		exp_cfg     = '0;
		conf_bytes  = '{8'h48, 8'h50, 8'h53, 8'h31};
		// first byte of the string sits at the top
		conf_str    = {conf_bytes[0], conf_bytes[1], conf_bytes[2], conf_bytes[3]};
		repeat (8) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;

		expect_eq("ioctl.download", 32'(ioctl.download), 32'h0);
		expect_eq("ioctl.wr", 32'(ioctl.wr), 32'h0);
		expect_eq("kbd_we", 32'(UUT.kbd_we), 32'h0);
		expect_eq("ps2_kbd_clk_out", 32'(ps2_kbd_clk_out), 32'h1);
		expect_eq("ps2_kbd_data_out", 32'(ps2_kbd_data_out), 32'h1);
		expect_eq("host_dout", 32'(host_dout), 32'h0);
		check_cfg();

		// config writes land one cycle after the strobe
		repeat (2) begin
			rnd = $random(seed);
			frame_begin();
			send_word(CMD_CFG);
			send_word(rnd[15:0]);
			exp_cfg.buttons            = rnd[1:0];
			exp_cfg.forced_scandoubler = rnd[4];
			check_cfg();
			frame_end();
			rnd = $random(seed);
			frame_begin();
			send_word(CMD_JOY0);
			send_word(rnd[15:0]);
			exp_cfg.joystick_0 = rnd[15:0];
			check_cfg();
			frame_end();
			rnd = $random(seed);
			frame_begin();
			send_word(CMD_JOY1);
			send_word(rnd[15:0]);
			exp_cfg.joystick_1 = rnd[15:0];
			check_cfg();
			frame_end();
			rnd = $random(seed);
			frame_begin();
			send_word(CMD_STATUS);
			send_word(rnd[15:0]);
			exp_cfg.status[15:0] = rnd[15:0];
			check_cfg();
			send_word(rnd[31:16]);
			exp_cfg.status[31:16] = rnd[31:16];
			check_cfg();
			frame_end();
		end

		frame_begin();
		send_word(CMD_CONF_STR);
		for (int k = 1; k <= STRLEN + 1; k++) begin
			if (k <= STRLEN) begin
				read_word(16'(k), {8'h00, conf_bytes[k-1]});
			end else begin
				read_word(16'(k), 16'h0000);
			end
		end
		frame_end();

		for (int n = 0; n < 3; n++) begin
			last_status = $random(seed);
			status_in   = last_status;
			status_set  = 1'b1;
			@(posedge clk_sys);
			#2;
			status_set = 1'b0;
			@(posedge clk_sys);
			#2;
		end
		frame_begin();
		send_word(CMD_STATUS_REQ);
		expect_eq("host_dout", 32'(host_dout), 32'h00A3);
		read_word(16'h0000, last_status[15:0]);
		read_word(16'h0000, last_status[31:16]);
		frame_end();

		// download with index, start, data words and end
		rnd = $random(seed);
		frame_begin();
		send_word(CMD_FILE_INDEX);
		send_word({8'h00, rnd[7:0]});
		frame_end();
		expect_eq("ioctl.index", 32'(ioctl.index), 32'(rnd[7:0]));
		frame_begin();
		send_word(CMD_FILE_TX);
		send_word(16'h00FF);
		expect_eq("ioctl.download", 32'(ioctl.download), 32'h1);
		frame_end();
		frame_begin();
		send_word(CMD_FILE_TX_DAT);
		for (int i = 0; i < DL_WORDS; i++) begin
			rnd = $random(seed);
			dl_q.push_back(rnd[7:0]);
			send_word(rnd[15:0]);
			wait_write_pulse();
		end
		frame_end();
		expect_eq("write pulse count", 32'(wr_seen), 32'(DL_WORDS));
		frame_begin();
		send_word(CMD_FILE_TX);
		send_word(16'h0000);
		expect_eq("ioctl.download", 32'(ioctl.download), 32'h0);
		expect_eq("ioctl.addr", 32'(ioctl.addr), 32'(DL_WORDS));
		frame_end();

		frame_begin();
		send_word(CMD_KBD);
		for (int i = 0; i < KBD_BYTES; i++) begin
			rnd = $random(seed);
			kbd_q.push_back(rnd[7:0]);
			send_word({8'h00, rnd[7:0]});
		end
		frame_end();
		while (frames_seen < KBD_BYTES) begin
			@(posedge clk_sys);
			#2;
		end

		repeat (16) begin
			ioctl_wait = 1'($random(seed));
			@(posedge clk_sys);
			#2;
		end
		ioctl_wait = 1'b0;
		repeat (2) @(posedge clk_sys);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
